// ==== sources.f ====
rtl/pkt_pkg.sv
rtl/frame_if.sv
rtl/pkt_ctrl.sv
rtl/fifo_write.sv
rtl/byte_fifo.sv
rtl/tx_checksum.sv
rtl/pkt_src_top.sv
verification/tb_pkt_src.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame source testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f \
    --top-module tb_pkt_src -Mdir obj_dir -o tb_pkt_src
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_pkt_src > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation clean"
exit 0

// ==== verification/tb_pkt_src.sv ====
`timescale 1ns/1ps

module tb_pkt_src
    import pkt_pkg::*;
();

    // total bytes over all frames for the watchdog
    localparam int MAX_BYTES   = 40 + 300 + 200 + 100;
    localparam int WDOG_CYCLES = 8 * MAX_BYTES + 2000;

    logic        clk;
    logic        rst;
    logic [3:0]  s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [3:0]  s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        tx_ready;

    logic [7:0]  rx_q[$];
    logic [15:0] exp_part;
    logic        rand_ready;
    string       cur_test;
    int          n_checks;
    int          errors;

    pkt_src_top #(
        .FIFO_DEPTH(16),
        .LEN_W     (12)
    ) dut0 (
        .clk(clk), .rst(rst),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [7:0] exp_byte(input int index, input logic [15:0] part);
        case (index)
            0: return 8'h55;
            1: return 8'hAA;
            2: return part[15:8];
            3: return part[7:0];
            default: return 8'(index % 256);
        endcase
    endfunction

    function automatic logic [15:0] exp_sum(input int len, input logic [15:0] part);
        logic [15:0] s;
        s = 16'd0;
        for (int i = 0; i < len; i++) begin
            s = s + {8'd0, exp_byte(i, part)};
        end
        return s;
    endfunction

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("test %-10s %s", name, (errors == err0) ? "ok" : "failed");
    endtask

    ////////////////////////////////////////////////////////////
    // axi4-lite bus tasks
    ////////////////////////////////////////////////////////////
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        s_awaddr  <= addr;
        s_awvalid <= 1'b1;
        s_wdata   <= data;
        s_wvalid  <= 1'b1;
        s_bready  <= 1'b1;
        @(posedge clk);
        while (!s_awready) @(posedge clk);
        check_val({cur_test, " wready"}, 32'd1, {31'd0, s_wready});
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        @(posedge clk);
        while (!s_bvalid) @(posedge clk);
        check_val({cur_test, " bresp"}, 32'd0, {30'd0, s_bresp});
        s_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        s_rready  <= 1'b1;
        @(posedge clk);
        while (!s_arready) @(posedge clk);
        s_arvalid <= 1'b0;
        @(posedge clk);
        while (!s_rvalid) @(posedge clk);
        check_val({cur_test, " rresp"}, 32'd0, {30'd0, s_rresp});
        data = s_rdata;
        s_rready <= 1'b0;
    endtask

    // one frame end to end with an optional second start while busy
    task automatic run_frame(input string name, input int len, input logic [15:0] part,
                             input logic rnd, input logic extra);
        logic [31:0] rd;
        logic [15:0] prev_cnt;
        int          err0;
        err0     = errors;
        cur_test = name;
        axil_read(ADDR_STATUS, rd);
        prev_cnt = rd[31:16];
        rx_q.delete();
        exp_part   <= part;
        rand_ready <= rnd;
        axil_write(ADDR_CFG, {part, 4'h0, 12'(len)});
        axil_write(ADDR_CTRL, 32'd1);
        if (extra) begin
            axil_read(ADDR_CTRL, rd);
            check_val({name, " busy"}, 32'd1, {31'd0, rd[1]});
            axil_write(ADDR_CTRL, 32'd1);
        end
        while (rx_q.size() < len) @(posedge clk);
        do begin
            axil_read(ADDR_CTRL, rd);
        end while (rd[1]);
        // any stray byte would show up here
        repeat (20) @(posedge clk);
        check_val({name, " length"}, 32'(len), 32'(rx_q.size()));
        axil_read(ADDR_STATUS, rd);
        check_val({name, " csum"}, {16'd0, exp_sum(len, part)}, {16'd0, rd[15:0]});
        check_val({name, " count"}, {16'd0, prev_cnt + 16'd1}, {16'd0, rd[31:16]});
        report_test(name, err0);
    endtask

    // stream sink and byte compare
    initial begin : stream_check
        tx_ready = 1'b0;
        forever begin
            @(posedge clk);
            if (tx_valid && tx_ready) begin
                check_val($sformatf("%s byte %0d", cur_test, rx_q.size()),
                          {24'd0, exp_byte(rx_q.size(), exp_part)}, {24'd0, tx_data});
                rx_q.push_back(tx_data);
            end
            if (rand_ready) begin
                tx_ready <= 1'($urandom_range(1, 0));
            end else begin
                tx_ready <= 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin : main
        logic [31:0] rd;
        logic [31:0] cfg_w;
        logic [15:0] part;
        int          len;
        int          err0;
        int          prev_cnt;
        void'($urandom(56));
        rst        = 1'b1;
        s_awaddr   = 4'd0;
        s_awvalid  = 1'b0;
        s_wdata    = 32'd0;
        s_wvalid   = 1'b0;
        s_bready   = 1'b0;
        s_araddr   = 4'd0;
        s_arvalid  = 1'b0;
        s_rready   = 1'b0;
        rand_ready = 1'b0;
        exp_part   = 16'd0;
        n_checks   = 0;
        errors     = 0;
        cur_test   = "reset";
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        err0 = errors;
        @(posedge clk);
        check_val("reset tx_valid", 32'd0, {31'd0, tx_valid});
        axil_read(ADDR_CTRL, rd);
        check_val("reset busy", 32'd0, {31'd0, rd[1]});
        axil_read(ADDR_STATUS, rd);
        check_val("reset status", 32'd0, rd);
        report_test("reset", err0);

        err0     = errors;
        cur_test = "cfg_rw";
        for (int k = 0; k < 4; k++) begin
            part  = 16'($urandom);
            cfg_w = {part, 4'h0, 12'($urandom_range(4095, 0))};
            axil_write(ADDR_CFG, cfg_w);
            axil_read(ADDR_CFG, rd);
            check_val("cfg_rw", cfg_w, rd);
        end
        report_test("cfg_rw", err0);

        run_frame("frame_40", 40, 16'h1234, 1'b0, 1'b0);
        run_frame("frame_300", 300, 16'hC0DE, 1'b0, 1'b0);
        len  = int'($urandom_range(200, 4));
        part = 16'($urandom);
        run_frame("frame_rand", len, part, 1'b1, 1'b0);
        run_frame("busy_start", 100, 16'hBEEF, 1'b0, 1'b1);

        // data_len below the header size is ignored
        err0     = errors;
        cur_test = "short_len";
        axil_read(ADDR_STATUS, rd);
        prev_cnt = int'(rd[31:16]);
        rx_q.delete();
        axil_write(ADDR_CFG, {16'h0F0F, 4'h0, 12'd3});
        axil_write(ADDR_CTRL, 32'd1);
        repeat (50) @(posedge clk);
        check_val("short_len bytes", 32'd0, 32'(rx_q.size()));
        axil_read(ADDR_CTRL, rd);
        check_val("short_len busy", 32'd0, {31'd0, rd[1]});
        axil_read(ADDR_STATUS, rd);
        check_val("short_len count", 32'(prev_cnt), {16'd0, rd[31:16]});
        report_test("short_len", err0);

        $display("%0d checks, %0d errors", n_checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/pkt_src_top.sv ====
`timescale 1ns/1ps

module pkt_src_top #(
    parameter int FIFO_DEPTH = 16,
    parameter int LEN_W      = 12
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [3:0]  s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready,
    output logic [7:0]  tx_data,
    output logic        tx_valid,
    input  logic        tx_ready
);

    logic [7:0]  fw_data;
    logic        fw_en;
    logic        fifo_full;
    logic        csum_clr;
    logic [15:0] csum;

    frame_if #(.LEN_W(LEN_W)) frm_bus ();

    ////////////////////////////////////////////////////////////
    // register block and frame writer
    ////////////////////////////////////////////////////////////
    pkt_ctrl #(
        .LEN_W(LEN_W)
    ) u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .frm       (frm_bus.ctrl),
        .csum_clr  (csum_clr),
        .csum      (csum)
    );

    fifo_write #(
        .LEN_W(LEN_W)
    ) u_writer (
        .clk     (clk),
        .rst     (rst),
        .frm     (frm_bus.writer),
        .full    (fifo_full),
        .wr_data (fw_data),
        .wr_en   (fw_en)
    );

    ////////////////////////////////////////////////////////////
    // byte path out
    ////////////////////////////////////////////////////////////
    byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (fw_data),
        .wr_en    (fw_en),
        .full     (fifo_full),
        .rd_data  (tx_data),
        .rd_valid (tx_valid),
        .rd_ready (tx_ready)
    );

    // sums what the writer pushes, not what leaves
    tx_checksum u_csum (
        .clk     (clk),
        .rst     (rst),
        .clr     (csum_clr),
        .wr_en   (fw_en),
        .wr_data (fw_data),
        .csum    (csum)
    );

endmodule

// ==== rtl/tx_checksum.sv ====
`timescale 1ns/1ps

module tx_checksum (
    input  logic        clk,
    input  logic        rst,
    input  logic        clr,
    input  logic        wr_en,
    input  logic [7:0]  wr_data,
    output logic [15:0] csum
);

    // plain additive sum, wraps at 16 bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            csum <= 16'd0;
        end else if (clr) begin
            csum <= 16'd0;
        end else if (wr_en) begin
            csum <= csum + {8'd0, wr_data};
        end
    end

endmodule

// ==== rtl/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] wr_data,
    input  logic       wr_en,
    output logic       full,
    output logic [7:0] rd_data,
    output logic       rd_valid,
    input  logic       rd_ready
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [7:0]  mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        empty;
    logic        do_wr;
    logic        do_rd;

    // extra pointer bit separates full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_wr = wr_en && !full;
    assign do_rd = rd_ready && !empty;

    // first word falls through
    assign rd_valid = !empty;
    assign rd_data  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

endmodule

// ==== rtl/fifo_write.sv ====
`timescale 1ns/1ps

module fifo_write
    import pkt_pkg::*;
#(
    parameter int LEN_W = 12
) (
    input  logic       clk,
    input  logic       rst,
    frame_if.writer    frm,
    input  logic       full,
    output logic [7:0] wr_data,
    output logic       wr_en
);

    wr_state_t        state;
    wr_state_t        next_state;
    logic [LEN_W-1:0] idx;
    logic             last_idx;

    assign last_idx = (idx == frm.data_len - LEN_W'(1));
    assign wr_en    = (state == WORK) && !full;
    assign frm.fd   = (state == LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: if (frm.fs) next_state = PREP;
            PREP: if (!full) next_state = HEAD;
            HEAD: next_state = WORK;
            WORK: if (last_idx && !full) next_state = LAST;
            // wait for control to drop fs
            LAST: if (!frm.fs) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // byte index, stalls while the fifo is full
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx <= '0;
        end else if (state == WORK) begin
            if (!full) begin
                idx <= idx + LEN_W'(1);
            end
        end else begin
            idx <= '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // byte select
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (idx)
            LEN_W'(0): wr_data = HDR_BYTE0;
            LEN_W'(1): wr_data = HDR_BYTE1;
            LEN_W'(2): wr_data = frm.part[15:8];
            LEN_W'(3): wr_data = frm.part[7:0];
            default:   wr_data = idx[7:0];
        endcase
    end

endmodule

// ==== rtl/pkt_ctrl.sv ====
`timescale 1ns/1ps

module pkt_ctrl
    import pkt_pkg::*;
#(
    parameter int LEN_W = 12
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [3:0]  s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready,
    frame_if.ctrl       frm,
    output logic        csum_clr,
    input  logic [15:0] csum
);

    cfg_word_u   cfg_reg;
    cfg_word_u   frm_cfg;
    logic        busy;
    logic        start_req;
    logic        wr_hs;
    logic        rd_hs;
    logic        len_ok;
    logic        launch;
    logic [15:0] frame_cnt;
    logic [31:0] rd_word;

    assign wr_hs  = s_awready && s_awvalid && s_wready && s_wvalid;
    assign rd_hs  = s_arready && s_arvalid;
    assign len_ok = (cfg_reg.f.data_len >= MIN_LEN);
    assign launch = start_req && !busy && len_ok;

    assign s_bresp = 2'b00;
    assign s_rresp = 2'b00;

    ////////////////////////////////////////////////////////////
    // axi4-lite handshakes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_awready <= 1'b0;
            s_wready  <= 1'b0;
            s_bvalid  <= 1'b0;
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
        end else begin
            // one-cycle accept, blocked while a response is pending
            s_awready <= s_awvalid && s_wvalid && !s_awready && !s_bvalid;
            s_wready  <= s_awvalid && s_wvalid && !s_awready && !s_bvalid;
            if (wr_hs) begin
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
            s_arready <= s_arvalid && !s_arready && !s_rvalid;
            if (rd_hs) begin
                s_rvalid <= 1'b1;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (s_araddr)
            ADDR_CTRL:   rd_word = {30'd0, busy, 1'b0};
            ADDR_CFG:    rd_word = cfg_reg.raw;
            ADDR_STATUS: rd_word = {frame_cnt, csum};
            default:     rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            s_rdata <= rd_word;
        end
    end

    ////////////////////////////////////////////////////////////
    // registers and frame sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_reg.raw <= 32'd0;
            start_req   <= 1'b0;
            csum_clr    <= 1'b0;
            frm.fs      <= 1'b0;
            busy        <= 1'b0;
            frame_cnt   <= 16'd0;
        end else begin
            start_req <= wr_hs && (s_awaddr == ADDR_CTRL) && s_wdata[0];
            if (wr_hs && (s_awaddr == ADDR_CFG)) begin
                cfg_reg.raw <= s_wdata;
            end
            csum_clr <= launch;
            if (launch) begin
                frm.fs <= 1'b1;
                busy   <= 1'b1;
            end else if (frm.fs && frm.fd) begin
                frm.fs    <= 1'b0;
                frame_cnt <= frame_cnt + 16'd1;
            end else if (busy && !frm.fs) begin
                // writer leaves LAST on this edge
                busy <= 1'b0;
            end
        end
    end

    // frame parameters frozen for the whole frame
    always_ff @(posedge clk) begin
        if (launch) begin
            frm_cfg <= cfg_reg;
        end
    end

    assign frm.data_len = LEN_W'(frm_cfg.f.data_len);
    assign frm.part     = frm_cfg.f.part;

endmodule

// ==== rtl/frame_if.sv ====
`timescale 1ns/1ps

interface frame_if #(
    parameter int LEN_W = 12
) ();

    logic             fs;
    logic             fd;
    logic [LEN_W-1:0] data_len;
    logic [15:0]      part;

    // control side starts a frame, writer reports it done
    modport ctrl (
        output fs,
        output data_len,
        output part,
        input  fd
    );

    modport writer (
        input  fs,
        input  data_len,
        input  part,
        output fd
    );

endinterface

// ==== rtl/pkt_pkg.sv ====
package pkt_pkg;

    ////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////
    localparam logic [3:0] ADDR_CTRL   = 4'h0;
    localparam logic [3:0] ADDR_CFG    = 4'h4;
    localparam logic [3:0] ADDR_STATUS = 4'h8;

    // sync pattern at the head of every frame
    localparam logic [7:0] HDR_BYTE0 = 8'h55;
    localparam logic [7:0] HDR_BYTE1 = 8'hAA;

    // two sync bytes plus two part bytes
    localparam logic [11:0] MIN_LEN = 12'd4;

    typedef enum logic [2:0] {
        IDLE = 3'h0,
        PREP = 3'h1,
        HEAD = 3'h2,
        WORK = 3'h3,
        LAST = 3'h4
    } wr_state_t;

    // cfg register, bus word or decoded fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [15:0] part;
            logic [3:0]  rsvd;
            logic [11:0] data_len;
        } f;
    } cfg_word_u;

endpackage
